// ==== hartChecker.sv ====
/*
  hart checker
  instruction-set model of the loaded program, compares every
  performed store and the final store count with the hart
*/
`include "wally_defs.svh"

module hartChecker #(
  parameter int numWords = 96
) (
  input  logic            clk,
  input  logic            reset,
  input  wallyPkg::xlenT  PCF,
  input  wallyPkg::xlenT  MemAdrE,
  input  wallyPkg::xlenT  WriteDataE,
  input  logic            MemReadE,
  input  logic            MemWriteE,
  input  logic            MemReadyE,
  input  wallyPkg::instrT prog [0:numWords-1],
  output int              errorCount,
  output int              storeCount,  // seen on the port
  output int              modelCount,  // made by the model
  output logic            checkDone
);
  timeunit 1ns;
  timeprecision 100ps;
  import wallyPkg::*;

  localparam xlenT haltAdr = `RESET_VECTOR + 4 * (numWords - 1);

  xlenT modelRegs [0:31];
  xlenT modelMem  [0:15];
  xlenT modelPc, expAdr, expData;
  bit   modelHalted, found, firstCycle;
  int   haltCycles, drains;

  function automatic xlenT aluResult(logic [2:0] f3, bit isSub, xlenT x, xlenT y);
    case (f3)
      `F3_ADD: return isSub ? x - y : x + y;
      `F3_SLT: return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
      `F3_XOR: return x ^ y;
      `F3_OR:  return x | y;
      default: return x & y;
    endcase
  endfunction

  // run the model up to its next store, or to the halt
  task automatic stepToStore(output bit hit, output xlenT adr, output xlenT data);
    instrT ins;
    xlenT  a, b, res, nextPc, immI, immS, immB, immJ;
    logic  writesRd;
    int    steps;
    hit   = 1'b0;
    adr   = '0;
    data  = '0;
    steps = 0;
    while (!hit && !modelHalted && steps < 4 * numWords) begin
      ins    = prog[modelPc[8:2]];
      a      = modelRegs[ins[19:15]];
      b      = modelRegs[ins[24:20]];
      immI   = {{20{ins[31]}}, ins[31:20]};
      immS   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      immB   = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
      immJ   = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
      res    = '0;
      nextPc = modelPc + 4;
      writesRd = (ins[6:0] == `OP_REG) || (ins[6:0] == `OP_IMM) || (ins[6:0] == `OP_LUI) ||
                 (ins[6:0] == `OP_LOAD) || (ins[6:0] == `OP_JAL);
      case (ins[6:0])
        `OP_REG:  res = aluResult(ins[14:12], ins[31:25] == `F7_SUB, a, b);
        `OP_IMM:  res = aluResult(ins[14:12], 1'b0, a, immI);
        `OP_LUI:  res = {ins[31:12], 12'b0};
        `OP_LOAD: begin
          res = a + immI;
          res = modelMem[res[5:2]];
        end
        `OP_STORE: begin
          hit  = 1'b1;
          adr  = a + immS;
          data = b;
          modelMem[adr[5:2]] = b;
        end
        `OP_BRANCH: if ((a == b) != (ins[14:12] == `F3_BNE)) nextPc = modelPc + immB;
        `OP_JAL: begin
          res    = modelPc + 4;  // link
          nextPc = modelPc + immJ;
        end
        default: ;
      endcase
      if (writesRd && ins[11:7] != 5'd0) modelRegs[ins[11:7]] = res;
      modelHalted = (nextPc == modelPc); // jal x0, 0
      modelPc     = nextPc;
      steps++;
    end
  endtask

  ////////////////////
  // compare
  ////////////////////
  // sampled at the edge, so these are the values settled before it
  always @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) modelRegs[i] = '0;
      for (int i = 0; i < 16; i++) modelMem[i] = '0;
      modelPc     = `RESET_VECTOR;
      modelHalted = 1'b0;
      errorCount  = 0;
      storeCount  = 0;
      modelCount  = 0;
      haltCycles  = 0;
      firstCycle  = 1'b1;
      checkDone   = 1'b0;
    end else if (!checkDone) begin
      if (firstCycle && PCF !== `RESET_VECTOR) begin
        errorCount++;
        $display("mismatch PCF after reset: got 0x%08h expected 0x%08h", PCF, `RESET_VECTOR);
      end
      if (firstCycle && (MemReadE !== 1'b0 || MemWriteE !== 1'b0)) begin
        errorCount++;
        $display("error: a data memory strobe is high right after reset");
      end
      firstCycle = 1'b0;
      if (MemWriteE && MemReadyE) begin
        storeCount++;
        stepToStore(found, expAdr, expData);
        if (!found) begin
          errorCount++;
          $display("error: store %0d performed after the model reached the halt", storeCount);
        end else begin
          modelCount++;
          if (MemAdrE !== expAdr) begin
            errorCount++;
            $display("mismatch MemAdrE: store %0d got 0x%08h expected 0x%08h",
                     storeCount, MemAdrE, expAdr);
          end
          if (WriteDataE !== expData) begin
            errorCount++;
            $display("mismatch WriteDataE: store %0d got 0x%08h expected 0x%08h",
                     storeCount, WriteDataE, expData);
          end
        end
      end
      // halt jal loops PCF over haltAdr .. haltAdr+8 as it resolves in E
      haltCycles = (PCF >= haltAdr) ? haltCycles + 1 : 0;
      if (haltCycles == 20) begin
        drains = 0;
        stepToStore(found, expAdr, expData);
        while (found && drains < numWords) begin  // stores the hart never made
          modelCount++;
          drains++;
          stepToStore(found, expAdr, expData);
        end
        if (storeCount != modelCount) begin
          errorCount++;
          $display("error: store count differs, hart performed %0d and model made %0d",
                   storeCount, modelCount);
        end
        checkDone = 1'b1;
      end
    end
  end

endmodule

// ==== hazard.sv ====
/*
  hazard unit
  forward selects, memory back-pressure stalls and branch flushes
*/
module hazard (
  input  wallyPkg::regAdrT Rs1D,
  input  wallyPkg::regAdrT Rs2D,
  input  wallyPkg::regAdrT Rs1E,
  input  wallyPkg::regAdrT Rs2E,
  input  wallyPkg::regAdrT RdW,
  input  logic             RegWriteW,
  input  logic             PCSrcE,
  input  logic             MemReadE,
  input  logic             MemWriteE,
  input  logic             MemReadyE,
  output logic             StallF,
  output logic             StallD,
  output logic             StallE,
  output logic             FlushD,
  output logic             FlushE,
  output wallyPkg::fwdSelT ForwardAE,
  output wallyPkg::fwdSelT ForwardBE
);
  import wallyPkg::*;

  logic WValidW;    // W writes a real register
  logic MemStallE;  // E access waiting on dmem

  assign WValidW = RegWriteW & (RdW != '0);

  // E sources take the W result
  assign ForwardAE = (WValidW && (Rs1E == RdW)) ? FWD_W : FWD_RF;
  assign ForwardBE = (WValidW && (Rs2E == RdW)) ? FWD_W : FWD_RF;

  ////////////////////
  // stalls and flushes
  ////////////////////
  // a D read of the W register is covered by the write-through,
  // so it never adds a stall of its own
  assign MemStallE = (MemReadE | MemWriteE) & ~MemReadyE;

  assign StallF = MemStallE;             // whole pipe holds
  assign StallD = MemStallE;
  assign StallE = MemStallE;

  assign FlushD = PCSrcE & ~StallD;      // kill the two younger slots
  assign FlushE = PCSrcE & ~StallE;

endmodule

// ==== ieu.sv ====
/*
  integer execution unit
  decode and register read in D, forwarding, ALU and branch
  resolution in E, result select in W
*/
`include "wally_defs.svh"

module ieu (
  input  logic             clk,
  input  logic             reset,
  input  logic             StallD,
  input  logic             StallE,
  input  logic             FlushE,
  input  wallyPkg::fwdSelT ForwardAE,
  input  wallyPkg::fwdSelT ForwardBE,
  input  wallyPkg::instrT  InstrD,
  input  wallyPkg::xlenT   PCD,
  output wallyPkg::regAdrT Rs1D,
  output wallyPkg::regAdrT Rs2D,
  output wallyPkg::regAdrT Rs1E,
  output wallyPkg::regAdrT Rs2E,
  output wallyPkg::regAdrT RdW,
  output logic             RegWriteW,
  output logic             PCSrcE,
  output wallyPkg::xlenT   PCTargetE,
  output wallyPkg::xlenT   MemAdrE,
  output wallyPkg::xlenT   WriteDataE,
  output logic             MemReadE,
  output logic             MemWriteE,
  input  wallyPkg::xlenT   ReadDataW
);
  import wallyPkg::*;

  logic [6:0] OpD, Funct7D;
  logic [2:0] Funct3D;
  regAdrT     RdD, RdE;
  xlenT       Rd1D, Rd2D, ImmD;
  xlenT       Rd1E, Rd2E, ImmE, PCE;
  aluOpT      AluOpD, AluOpE;
  logic       RegWriteD, AluSrcBD, MemReadD, MemWriteD, BranchD, JumpD;
  logic       RegWriteE, AluSrcBE, BranchE, JumpE, BneE;
  xlenT       SrcAE, SrcBE, RegBE, AluResultE, ResultE;
  xlenT       AluResultW, ResultW;
  logic       LoadW;

  ////////////////////
  // decode
  ////////////////////
  assign OpD     = InstrD[6:0];
  assign Funct3D = InstrD[14:12];
  assign Funct7D = InstrD[31:25];
  assign RdD     = InstrD[11:7];
  assign Rs1D    = InstrD[19:15];
  assign Rs2D    = InstrD[24:20];

  always_comb begin
    RegWriteD = 1'b0; // anything unmatched stays a nop
    AluSrcBD  = 1'b0;
    MemReadD  = 1'b0;
    MemWriteD = 1'b0;
    BranchD   = 1'b0;
    JumpD     = 1'b0;
    AluOpD    = ALU_ADD;
    ImmD      = {{(`XLEN-12){InstrD[31]}}, InstrD[31:20]}; // I-type
    case (OpD)
      `OP_REG: if ((Funct7D == `F7_BASE) || (Funct7D == `F7_SUB && Funct3D == `F3_ADD)) begin
        RegWriteD = 1'b1;
        case (Funct3D)
          `F3_ADD: AluOpD = Funct7D[5] ? ALU_SUB : ALU_ADD;
          `F3_SLT: AluOpD = ALU_SLT;
          `F3_XOR: AluOpD = ALU_XOR;
          `F3_OR:  AluOpD = ALU_OR;
          `F3_AND: AluOpD = ALU_AND;
          default: RegWriteD = 1'b0; // shifts etc not supported
        endcase
      end
      `OP_IMM: begin
        RegWriteD = 1'b1;
        AluSrcBD  = 1'b1;
        case (Funct3D)
          `F3_ADD: AluOpD = ALU_ADD;
          `F3_SLT: AluOpD = ALU_SLT;
          `F3_XOR: AluOpD = ALU_XOR;
          `F3_OR:  AluOpD = ALU_OR;
          `F3_AND: AluOpD = ALU_AND;
          default: RegWriteD = 1'b0;
        endcase
      end
      `OP_LUI: begin
        RegWriteD = 1'b1;
        AluSrcBD  = 1'b1;
        AluOpD    = ALU_PASSB;
        ImmD      = {InstrD[31:12], 12'b0};
      end
      `OP_LOAD: if (Funct3D == `F3_LW) begin
        RegWriteD = 1'b1;
        MemReadD  = 1'b1;
        AluSrcBD  = 1'b1;
      end
      `OP_STORE: if (Funct3D == `F3_SW) begin
        MemWriteD = 1'b1;
        AluSrcBD  = 1'b1;
        ImmD      = {{(`XLEN-12){InstrD[31]}}, InstrD[31:25], InstrD[11:7]};
      end
      `OP_BRANCH: begin
        BranchD = (Funct3D == `F3_BEQ) || (Funct3D == `F3_BNE);
        ImmD    = {{(`XLEN-12){InstrD[31]}}, InstrD[7], InstrD[30:25], InstrD[11:8], 1'b0};
      end
      `OP_JAL: begin
        JumpD     = 1'b1;
        RegWriteD = 1'b1; // link
        ImmD      = {{(`XLEN-20){InstrD[31]}}, InstrD[19:12], InstrD[20], InstrD[30:21], 1'b0};
      end
      default: ;
    endcase
  end

  regFile rf (.clk, .reset, .Rs1D, .Rs2D, .RdW, .RegWriteW, .ResultW, .Rd1D, .Rd2D);

  ////////////////////
  // D -> E register
  ////////////////////
  always_ff @(posedge clk) begin
    if (reset | FlushE) begin // bubble
      {RegWriteE, MemReadE, MemWriteE, BranchE, JumpE, AluSrcBE, BneE} <= '0;
      AluOpE <= ALU_ADD;
    end else if (~StallE) begin
      {RegWriteE, MemReadE, MemWriteE} <= {RegWriteD, MemReadD, MemWriteD};
      {BranchE, JumpE, AluSrcBE} <= {BranchD, JumpD, AluSrcBD};
      BneE   <= (Funct3D == `F3_BNE);
      AluOpE <= AluOpD;
    end
  end

  always_ff @(posedge clk) begin
    if (~StallE) begin // datapath payload
      {Rd1E, Rd2E, ImmE, PCE} <= {Rd1D, Rd2D, ImmD, PCD};
      {Rs1E, Rs2E, RdE} <= {Rs1D, Rs2D, RdD};
    end
  end

  ////////////////////
  // execute
  ////////////////////
  assign SrcAE = (ForwardAE == FWD_W) ? ResultW : Rd1E;
  assign RegBE = (ForwardBE == FWD_W) ? ResultW : Rd2E; // also store data
  assign SrcBE = AluSrcBE ? ImmE : RegBE;

  always_comb begin
    case (AluOpE)
      ALU_ADD:   AluResultE = SrcAE + SrcBE;
      ALU_SUB:   AluResultE = SrcAE - SrcBE;
      ALU_AND:   AluResultE = SrcAE & SrcBE;
      ALU_OR:    AluResultE = SrcAE | SrcBE;
      ALU_XOR:   AluResultE = SrcAE ^ SrcBE;
      ALU_SLT:   AluResultE = {{(`XLEN-1){1'b0}}, $signed(SrcAE) < $signed(SrcBE)};
      ALU_PASSB: AluResultE = SrcBE;
      default:   AluResultE = '0;
    endcase
  end

  // beq/bne compare the register operands directly
  assign PCSrcE     = JumpE | (BranchE & ((SrcAE == RegBE) ^ BneE));
  assign PCTargetE  = PCE + ImmE;
  assign MemAdrE    = AluResultE;  // base + offset
  assign WriteDataE = RegBE;
  assign ResultE    = JumpE ? PCE + `XLEN'd4 : AluResultE; // jal links pc+4

  ////////////////////
  // E -> W register
  ////////////////////
  // W holds with E so forwarding into a held E stays valid
  always_ff @(posedge clk) begin
    if (reset) begin
      RegWriteW <= 1'b0;
      LoadW     <= 1'b0;
    end else if (~StallE) begin
      RegWriteW <= RegWriteE;
      LoadW     <= MemReadE;
    end
  end

  always_ff @(posedge clk) begin
    if (~StallE) begin
      RdW        <= RdE;
      AluResultW <= ResultE;
    end
  end

  assign ResultW = LoadW ? ReadDataW : AluResultW; // writeback select

endmodule

// ==== ifu.sv ====
/*
  instruction fetch unit
  PC register, next-PC select and the F-to-D pipeline register
*/
`include "wally_defs.svh"

module ifu (
  input  logic           clk,
  input  logic           reset,
  input  logic           StallF,
  input  logic           StallD,
  input  logic           FlushD,
  input  logic           PCSrcE,     // taken branch / jal in E
  input  wallyPkg::xlenT PCTargetE,
  output wallyPkg::xlenT PCF,
  input  wallyPkg::instrT InstrF,    // combinational from imem
  output wallyPkg::instrT InstrD,
  output wallyPkg::xlenT PCD
);
  import wallyPkg::*;

  xlenT PCPlus4F;
  xlenT PCNextF;

  ////////////////////
  // next pc
  ////////////////////
  assign PCPlus4F = PCF + `XLEN'd4;
  assign PCNextF  = PCSrcE ? PCTargetE : PCPlus4F; // redirect wins

  always_ff @(posedge clk) begin
    if (reset) PCF <= `RESET_VECTOR;
    else if (~StallF) PCF <= PCNextF;
  end

  ////////////////////
  // F -> D register
  ////////////////////
  // a flushed or reset slot becomes a nop
  always_ff @(posedge clk) begin
    if (reset | FlushD) InstrD <= `NOP_INSTR;
    else if (~StallD) InstrD <= InstrF;
  end

  always_ff @(posedge clk) begin
    if (~StallD) PCD <= PCF; // payload, only meaningful with InstrD
  end

endmodule

// ==== lsu.sv ====
/*
  load/store unit
  word-aligned data memory port, load data registered into W
*/
`include "wally_defs.svh"

module lsu (
  input  logic           clk,
  input  logic           reset,
  input  logic           StallE,
  // from ieu
  input  wallyPkg::xlenT MemAdrE,
  input  wallyPkg::xlenT WriteDataE,
  input  logic           MemReadE,
  input  logic           MemWriteE,
  // data memory side
  output wallyPkg::xlenT MemAdr,
  output wallyPkg::xlenT WriteData,
  output logic           MemRead,
  output logic           MemWrite,
  input  wallyPkg::xlenT ReadDataE,  // combinational from dmem
  // to writeback
  output wallyPkg::xlenT ReadDataW
);
  import wallyPkg::*;

  // word only, low bits dropped
  assign MemAdr    = {MemAdrE[`XLEN-1:2], 2'b00};
  assign WriteData = WriteDataE;
  assign MemRead   = MemReadE;
  assign MemWrite  = MemWriteE;

  ////////////////////
  // load capture
  ////////////////////
  always_ff @(posedge clk) begin
    if (reset) ReadDataW <= '0;
    else if (~StallE) ReadDataW <= ReadDataE; // taken only once ready
  end

endmodule

// ==== regFile.sv ====
/*
  integer register file, two read ports and one write port
  x0 reads zero, W writes pass straight through to the D reads
*/
`include "wally_defs.svh"

module regFile (
  input  logic             clk,
  input  logic             reset,
  input  wallyPkg::regAdrT Rs1D,
  input  wallyPkg::regAdrT Rs2D,
  input  wallyPkg::regAdrT RdW,
  input  logic             RegWriteW,
  input  wallyPkg::xlenT   ResultW,
  output wallyPkg::xlenT   Rd1D,
  output wallyPkg::xlenT   Rd2D
);
  import wallyPkg::*;

  xlenT Regs [1:31]; // no storage for x0

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) Regs[i] <= '0; // start from a known state
    end else if (RegWriteW && (RdW != '0)) begin
      Regs[RdW] <= ResultW;
    end
  end

  // write-through from W, x0 hardwired
  assign Rd1D = (Rs1D == '0) ? '0 :
                (RegWriteW && (Rs1D == RdW)) ? ResultW : Regs[Rs1D];
  assign Rd2D = (Rs2D == '0) ? '0 :
                (RegWriteW && (Rs2D == RdW)) ? ResultW : Regs[Rs2D];

endmodule

// ==== tbWallyHart.sv ====
/*
  testbench for the four-stage hart
  random RV32I subset program, instruction and data memories,
  random data-side stalls, checker instance
*/
`include "wally_defs.svh"

module tbWallyHart;
  timeunit 1ns;
  timeprecision 100ps;
  import wallyPkg::*;

  localparam int numWords      = 96;   // last word is the halt
  localparam int timeoutCycles = 5000;

  logic       clk, reset;
  xlenT       PCF, MemAdrE, WriteDataE, ReadDataE;
  instrT      InstrF;
  logic       MemReadE, MemWriteE, MemReadyE;
  instrT      prog [0:numWords-1];
  xlenT       dmem [0:15];            // 64 bytes, offsets 0..60
  int         errorCount, storeCount, modelCount, cycles;
  logic       checkDone;
  logic [2:0] aluF3 [0:4] = '{`F3_ADD, `F3_SLT, `F3_XOR, `F3_OR, `F3_AND};

  wallyPipelinedHart dut (.*);

  hartChecker #(.numWords(numWords)) chk (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  ////////////////////
  // memories
  ////////////////////
  // past the program the fetch sees nops
  assign InstrF    = (PCF < 4 * numWords) ? prog[PCF[8:2]] : `NOP_INSTR;
  assign ReadDataE = dmem[MemAdrE[5:2]];

  always @(posedge clk) begin
    if (MemWriteE && MemReadyE) dmem[MemAdrE[5:2]] <= WriteDataE;
  end

  // random program, registers x0..x7, forward control flow only
  task automatic buildProgram();
    int          kind, skip;
    regAdrT      rd, rs1, rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm, off;
    logic [12:0] br;
    logic [20:0] jmp;
    logic [19:0] upper;
    for (int i = 0; i < numWords - 1; i++) begin
      kind  = $urandom % 100;
      rd    = $urandom % 8;
      rs1   = $urandom % 8;
      rs2   = $urandom % 8;
      f3    = aluF3[$urandom % 5];
      f7    = (f3 == `F3_ADD && ($urandom % 2)) ? `F7_SUB : `F7_BASE;
      imm   = $urandom;
      upper = $urandom;
      off   = ($urandom % 16) * 4;  // lw/sw base x0
      skip  = 1 + $urandom % (((numWords - 1 - i) < 8) ? (numWords - 1 - i) : 8);
      br    = skip * 4;
      jmp   = skip * 4;
      if (kind < 20)      prog[i] = {f7, rs2, rs1, f3, rd, `OP_REG};
      else if (kind < 40) prog[i] = {imm, rs1, f3, rd, `OP_IMM};
      else if (kind < 48) prog[i] = {upper, rd, `OP_LUI};
      else if (kind < 60) prog[i] = {off, 5'd0, `F3_LW, rd, `OP_LOAD};
      else if (kind < 80) prog[i] = {off[11:5], rs2, 5'd0, `F3_SW, off[4:0], `OP_STORE};
      else if (kind < 90) begin
        f3      = ($urandom % 2) ? `F3_BNE : `F3_BEQ;
        prog[i] = {br[12], br[10:5], rs2, rs1, f3, br[4:1], br[11], `OP_BRANCH};
      end else prog[i] = {jmp[20], jmp[10:1], jmp[11], jmp[19:12], rd, `OP_JAL};
    end
    prog[numWords-1] = {20'b0, 5'd0, `OP_JAL}; // jal x0, 0 as halt
  endtask

  ////////////////////
  // stimulus
  ////////////////////
  initial begin
    void'($urandom(49));
    reset     = 1'b1;
    MemReadyE = 1'b1;
    for (int i = 0; i < 16; i++) dmem[i] = '0;
    buildProgram();
    repeat (2) @(posedge clk);
    #1 reset = 1'b0;
    cycles = 0;
    // checker raises checkDone once PCF has settled on the halt
    while (!checkDone && cycles < timeoutCycles) begin
      @(posedge clk);
      #1 MemReadyE = ($urandom % 4) != 0;  // low about a quarter of the time
      cycles++;
    end
    if (!checkDone) $display("timeout: hart did not settle at the halt within %0d cycles",
                             timeoutCycles);
    $display("errors: %0d, stores performed: %0d, stores expected: %0d",
             errorCount, storeCount, modelCount);
    if (checkDone && errorCount == 0) $display("Simulation completed successfully");
    else $display("Simulation failed");
    $finish;
  end

endmodule

// ==== wallyHart.f ====
+incdir+.
wallyPkg.sv
ifu.sv
regFile.sv
ieu.sv
lsu.sv
hazard.sv
wallyPipelinedHart.sv
hartChecker.sv
tbWallyHart.sv

// ==== wallyPipelinedHart.sv ====
/*
  four-stage RV32I subset hart
  fetch, integer execution, load/store and hazard units
  wired to the instruction and data memory ports
*/
module wallyPipelinedHart (
  input  logic            clk,
  input  logic            reset,
  output wallyPkg::xlenT  PCF,
  input  wallyPkg::instrT InstrF,
  output wallyPkg::xlenT  MemAdrE,
  output wallyPkg::xlenT  WriteDataE,
  output logic            MemReadE,
  output logic            MemWriteE,
  input  wallyPkg::xlenT  ReadDataE,
  input  logic            MemReadyE
);
  import wallyPkg::*;

  // pipeline control
  logic   StallF, StallD, StallE;
  logic   FlushD, FlushE;
  fwdSelT ForwardAE, ForwardBE;

  // F -> D
  instrT  InstrD;
  xlenT   PCD;

  // register numbers for hazard checks
  regAdrT Rs1D, Rs2D, Rs1E, Rs2E, RdW;
  logic   RegWriteW;

  // redirect
  logic   PCSrcE;
  xlenT   PCTargetE;

  // ieu <-> lsu
  xlenT   IeuAdrE, IeuWriteDataE, ReadDataW;
  logic   IeuReadE, IeuWriteE;

  ////////////////////
  // units
  ////////////////////
  ifu ifu (.*); // pc and fetch register

  ieu ieu (
    .MemAdrE(IeuAdrE), .WriteDataE(IeuWriteDataE),
    .MemReadE(IeuReadE), .MemWriteE(IeuWriteE),
    .*); // decode, regfile, alu, branches

  lsu lsu (
    .MemAdrE(IeuAdrE), .WriteDataE(IeuWriteDataE),
    .MemReadE(IeuReadE), .MemWriteE(IeuWriteE),
    .MemAdr(MemAdrE), .WriteData(WriteDataE),
    .MemRead(MemReadE), .MemWrite(MemWriteE),
    .*); // dmem port and load capture

  hazard hzu (.MemReadE(IeuReadE), .MemWriteE(IeuWriteE), .*); // stall, flush, fwd

endmodule

// ==== wallyPkg.sv ====
/*
  shared types of the hart: word, instruction and register
  number widths, ALU operation codes, forward selects
*/
`include "wally_defs.svh"

package wallyPkg;

  typedef logic [`XLEN-1:0] xlenT;   // data or address word
  typedef logic [31:0]      instrT;  // always 32 bits, no compressed
  typedef logic [4:0]       regAdrT; // x0..x31

  // ALU operation, decoded in D, used in E
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASSB  // lui
  } aluOpT;

  // operand source in E
  typedef enum logic {
    FWD_RF,  // value read in D
    FWD_W    // result being written back
  } fwdSelT;

endpackage

// ==== wally_defs.svh ====
/*
  hart-wide constants: data width, reset vector and
  the opcode / funct encodings of the RV32I subset
*/
`ifndef WALLY_DEFS_SVH
`define WALLY_DEFS_SVH

`define XLEN         32
`define RESET_VECTOR 32'h0000_0000
`define NOP_INSTR    32'h0000_0013   // addi x0, x0, 0

// major opcodes
`define OP_REG    7'b0110011
`define OP_IMM    7'b0010011
`define OP_LUI    7'b0110111
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011
`define OP_BRANCH 7'b1100011
`define OP_JAL    7'b1101111

// funct3 / funct7
`define F3_ADD  3'b000
`define F3_SLT  3'b010
`define F3_XOR  3'b100
`define F3_OR   3'b110
`define F3_AND  3'b111
`define F3_LW   3'b010
`define F3_SW   3'b010
`define F3_BEQ  3'b000
`define F3_BNE  3'b001
`define F7_BASE 7'b0000000
`define F7_SUB  7'b0100000

`endif
